// ==== rv_ls_pkg.sv ====
package rv_ls_pkg;

    // datapath and instruction widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // major opcodes used by this stage
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // load/store funct3, stores use the signed codes for b/h/w/d
    localparam logic [2:0] MEM_B  = 3'b000;
    localparam logic [2:0] MEM_H  = 3'b001;
    localparam logic [2:0] MEM_W  = 3'b010;
    localparam logic [2:0] MEM_D  = 3'b011;
    localparam logic [2:0] MEM_BU = 3'b100;
    localparam logic [2:0] MEM_HU = 3'b101;
    localparam logic [2:0] MEM_WU = 3'b110;

    // csr funct3, immediate forms arrive with the operand already resolved
    localparam logic [2:0] CSR_RW  = 3'b001;
    localparam logic [2:0] CSR_RS  = 3'b010;
    localparam logic [2:0] CSR_RC  = 3'b011;
    localparam logic [2:0] CSR_RWI = 3'b101;
    localparam logic [2:0] CSR_RSI = 3'b110;
    localparam logic [2:0] CSR_RCI = 3'b111;

    // machine csr addresses
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // environment call from m-mode
    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

    // S-format view of an instruction word
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    // I-format view, imm12 doubles as the csr address
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        s_view_t s_view;
        i_view_t i_view;
    } instr_u;

    // decoded memory strobes
    typedef struct packed {
        logic       wren;
        logic       rden;
        logic [2:0] memop;
    } ls_ctrl_t;

    // one RAM access per cycle
    typedef struct packed {
        logic            wr_en;
        logic [31:0]     index;
        logic [XLEN-1:0] wr_data;
        logic [7:0]      byte_mask;
    } mem_req_t;

endpackage

// ==== ls_ctrl.sv ====
module ls_ctrl
    import rv_ls_pkg::*;
(
    input  instr_u          instr_i,
    input  instr_u          instr_last_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] wb_data_i,
    output ls_ctrl_t        ctrl_o,
    output logic [XLEN-1:0] st_data_o
);

    logic last_is_load;
    logic rs2_hit;
    logic fwd_sel;

    // strobes straight from the opcode field
    always_comb begin
        ctrl_o.wren  = (instr_i.s_view.opcode == OPC_STORE);
        ctrl_o.rden  = (instr_i.i_view.opcode == OPC_LOAD);
        ctrl_o.memop = instr_i.i_view.funct3;
    end

    // older load has not reached the regfile yet
    assign last_is_load = (instr_last_i.i_view.opcode == OPC_LOAD);
    assign rs2_hit      = (instr_last_i.i_view.rd == instr_i.s_view.rs2);
    assign fwd_sel      = last_is_load && rs2_hit;

    // take the loaded value instead of the stale register
    always_comb begin
        if (fwd_sel) begin
            st_data_o = wb_data_i;
        end else begin
            st_data_o = rs2_i;
        end
    end

endmodule

// ==== lsu.sv ====
module lsu
    import rv_ls_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic            clk,
    input  ls_ctrl_t        ctrl_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] st_data_i,
    output mem_req_t        ram_req_o,
    input  logic [XLEN-1:0] ram_rdata_i,
    output logic [XLEN-1:0] ls_res_o
);

    logic [2:0]      byte_off;
    logic [7:0]      size_mask;
    logic            aligned;
    logic [XLEN-1:0] rd_shifted;
    logic [XLEN-1:0] rd_ext;

    assign byte_off = addr_i[2:0];

    // bytes touched by each access width
    always_comb begin
        case (ctrl_i.memop[1:0])
            2'b00:   size_mask = 8'b0000_0001;
            2'b01:   size_mask = 8'b0000_0011;
            2'b10:   size_mask = 8'b0000_1111;
            default: size_mask = 8'b1111_1111;
        endcase
    end

    // natural alignment per width
    always_comb begin
        case (ctrl_i.memop[1:0])
            2'b00:   aligned = 1'b1;
            2'b01:   aligned = (byte_off[0] == 1'b0);
            2'b10:   aligned = (byte_off[1:0] == 2'b00);
            default: aligned = (byte_off == 3'b000);
        endcase
    end

    // store path, data moved into its byte lane
    always_comb begin
        ram_req_o.wr_en     = ctrl_i.wren;
        ram_req_o.index     = addr_i[34:3];
        ram_req_o.wr_data   = st_data_i << {byte_off, 3'b000};
        ram_req_o.byte_mask = ctrl_i.wren ? (size_mask << byte_off) : 8'h00;
    end

    // load path, addressed item lands at bit 0
    assign rd_shifted = ram_rdata_i >> {byte_off, 3'b000};

    always_comb begin
        case (ctrl_i.memop)
            MEM_B:   rd_ext = {{56{rd_shifted[7]}}, rd_shifted[7:0]};
            MEM_H:   rd_ext = {{48{rd_shifted[15]}}, rd_shifted[15:0]};
            MEM_W:   rd_ext = {{32{rd_shifted[31]}}, rd_shifted[31:0]};
            MEM_D:   rd_ext = rd_shifted;
            MEM_BU:  rd_ext = {56'b0, rd_shifted[7:0]};
            MEM_HU:  rd_ext = {48'b0, rd_shifted[15:0]};
            MEM_WU:  rd_ext = {32'b0, rd_shifted[31:0]};
            default: rd_ext = '0;
        endcase
    end

    // quiet bus when nothing is loaded
    assign ls_res_o = ctrl_i.rden ? rd_ext : '0;

    // decoder never flags both directions
    a_single_dir: assert property (@(posedge clk) !(ctrl_i.wren && ctrl_i.rden))
        else $error("load and store strobes both set");

    // aligned accesses only, the RAM has no split path
    a_aligned: assert property (@(posedge clk)
        (ctrl_i.wren || ctrl_i.rden) |-> aligned)
        else $error("misaligned access at %h", addr_i);

    a_in_range: assert property (@(posedge clk)
        (ctrl_i.wren || ctrl_i.rden) |-> (ram_req_o.index < 32'(RAM_WORDS)))
        else $error("access beyond RAM at %h", addr_i);

endmodule

// ==== data_ram.sv ====
module data_ram
    import rv_ls_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic            clk,
    input  mem_req_t        req_i,
    output logic [XLEN-1:0] rdata_o
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    localparam int NBYTES = XLEN / 8;

    logic [XLEN-1:0] mem [RAM_WORDS];
    logic [AW-1:0]   idx;

    // only the low index bits select a word
    assign idx = req_i.index[AW-1:0];

    // combinational read, same-cycle data for the load path
    assign rdata_o = mem[idx];

    // per-byte write on the rising edge
    always_ff @(posedge clk) begin
        if (req_i.wr_en) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (req_i.byte_mask[b]) begin
                    mem[idx][b*8 +: 8] <= req_i.wr_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== csr_unit.sv ====
module csr_unit
    import rv_ls_pkg::*;
#(
    parameter logic [XLEN-1:0] MTVEC_RESET = 64'h0000_0000_8000_0000
) (
    input  logic            clk,
    input  logic            reset_i,
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] operand_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            trap_i,
    output logic [XLEN-1:0] csr_data_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;

    logic [11:0]     csr_addr;
    logic [2:0]      funct3;
    logic            is_csr;
    logic            addr_hit;
    logic            csr_we;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;

    assign csr_addr = instr_i.i_view.imm12;
    assign funct3   = instr_i.i_view.funct3;

    // SYSTEM with a csr funct3, ecall/ebreak use funct3 0
    always_comb begin
        is_csr = 1'b0;
        if (instr_i.i_view.opcode == OPC_SYSTEM) begin
            case (funct3)
                CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI: is_csr = 1'b1;
                default: is_csr = 1'b0;
            endcase
        end
    end

    // old value, unknown addresses read as zero
    always_comb begin
        addr_hit = 1'b1;
        case (csr_addr)
            CSR_MSTATUS: old_val = mstatus_q;
            CSR_MTVEC:   old_val = mtvec_q;
            CSR_MEPC:    old_val = mepc_q;
            CSR_MCAUSE:  old_val = mcause_q;
            default: begin
                old_val  = '0;
                addr_hit = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            CSR_RW, CSR_RWI: new_val = operand_i;
            CSR_RS, CSR_RSI: new_val = old_val | operand_i;
            CSR_RC, CSR_RCI: new_val = old_val & ~operand_i;
            default:         new_val = old_val;
        endcase
    end

    // a trapping instruction does not retire its csr write
    assign csr_we = is_csr && addr_hit && !trap_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_q <= '0;
            mtvec_q   <= MTVEC_RESET;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap_i) begin
            mepc_q   <= pc_i;
            mcause_q <= CAUSE_ECALL_M;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MSTATUS: mstatus_q <= new_val;
                // direct mode only, base is word aligned
                CSR_MTVEC:   mtvec_q <= {new_val[XLEN-1:2], 2'b00};
                CSR_MEPC:    mepc_q <= new_val;
                default:     mcause_q <= new_val;
            endcase
        end
    end

    assign csr_data_o = is_csr ? old_val : '0;
    assign mtvec_o    = mtvec_q;
    assign mepc_o     = mepc_q;

    // holds for the reset value as well as every write
    a_mtvec_align: assert property (@(posedge clk) disable iff (reset_i)
        mtvec_o[1:0] == 2'b00)
        else $error("mtvec base not word aligned");

endmodule

// ==== ls_stage.sv ====
module ls_stage
    import rv_ls_pkg::*;
#(
    parameter int              RAM_WORDS   = 256,
    parameter logic [XLEN-1:0] MTVEC_RESET = 64'h0000_0000_8000_0000
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] alures_i,
    input  logic [XLEN-1:0] rs2_i,
    input  instr_u          instr_i,
    input  instr_u          instr_last_i,
    input  logic [XLEN-1:0] wb_data_i,
    input  logic            trap_i,
    output logic [XLEN-1:0] ls_res_o,
    output logic [XLEN-1:0] csr_data_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    ls_ctrl_t        ctrl;
    logic [XLEN-1:0] st_data;
    mem_req_t        ram_req;
    logic [XLEN-1:0] ram_rdata;

    ls_ctrl i_ls_ctrl (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .ctrl_o       (ctrl),
        .st_data_o    (st_data)
    );

    // alu result is the effective address for loads and stores
    lsu #(.RAM_WORDS(RAM_WORDS)) i_lsu (
        .clk         (clk),
        .ctrl_i      (ctrl),
        .addr_i      (alures_i),
        .st_data_i   (st_data),
        .ram_req_o   (ram_req),
        .ram_rdata_i (ram_rdata),
        .ls_res_o    (ls_res_o)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) i_data_ram (
        .clk     (clk),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

    // and the resolved csr operand for SYSTEM instructions
    csr_unit #(.MTVEC_RESET(MTVEC_RESET)) i_csr_unit (
        .clk        (clk),
        .reset_i    (reset_i),
        .instr_i    (instr_i),
        .operand_i  (alures_i),
        .pc_i       (pc_i),
        .trap_i     (trap_i),
        .csr_data_o (csr_data_o),
        .mtvec_o    (mtvec_o),
        .mepc_o     (mepc_o)
    );

endmodule

// ==== tb_ls_stage.sv ====
module tb_ls_stage
    import rv_ls_pkg::*;
();

    localparam int              N_WORDS    = 64;
    localparam logic [XLEN-1:0] MTVEC_RST  = 64'h0000_0000_0000_4000;
    // the tests take about 1700 cycles
    localparam int              MAX_CYCLES = 3000;
    localparam logic [6:0]      OPC_OPIMM  = 7'b0010011;

    logic            clk;
    logic            reset_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] alures_i;
    logic [XLEN-1:0] rs2_i;
    instr_u          instr_i;
    instr_u          instr_last_i;
    logic [XLEN-1:0] wb_data_i;
    logic            trap_i;
    logic [XLEN-1:0] ls_res_o;
    logic [XLEN-1:0] csr_data_o;
    logic [XLEN-1:0] mtvec_o;
    logic [XLEN-1:0] mepc_o;

    // reference memory, one entry per byte
    logic [7:0]      mem_m [N_WORDS*8];
    logic [XLEN-1:0] mstatus_m;
    logic [XLEN-1:0] mtvec_m;
    logic [XLEN-1:0] mepc_m;
    logic [XLEN-1:0] mcause_m;
    integer          seed;
    int              cycle_cnt = 0;

    ls_stage #(.RAM_WORDS(N_WORDS), .MTVEC_RESET(MTVEC_RST)) i_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .pc_i         (pc_i),
        .alures_i     (alures_i),
        .rs2_i        (rs2_i),
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .wb_data_i    (wb_data_i),
        .trap_i       (trap_i),
        .ls_res_o     (ls_res_o),
        .csr_data_o   (csr_data_o),
        .mtvec_o      (mtvec_o),
        .mepc_o       (mepc_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic logic [XLEN-1:0] rand64();
        return {rand32(), rand32()};
    endfunction

    function automatic instr_u enc_load(logic [2:0] f3, logic [4:0] rd);
        instr_u ins;
        ins = '0;
        ins.i_view.opcode = OPC_LOAD;
        ins.i_view.funct3 = f3;
        ins.i_view.rd     = rd;
        ins.i_view.rs1    = 5'd2;
        return ins;
    endfunction

    function automatic instr_u enc_store(logic [2:0] f3, logic [4:0] rs2);
        instr_u ins;
        ins = '0;
        ins.s_view.opcode = OPC_STORE;
        ins.s_view.funct3 = f3;
        ins.s_view.rs2    = rs2;
        ins.s_view.rs1    = 5'd2;
        return ins;
    endfunction

    function automatic instr_u enc_csr(logic [2:0] f3, logic [11:0] addr);
        instr_u ins;
        ins = '0;
        ins.i_view.opcode = OPC_SYSTEM;
        ins.i_view.funct3 = f3;
        ins.i_view.imm12  = addr;
        ins.i_view.rd     = 5'd10;
        return ins;
    endfunction

    function automatic instr_u enc_nop();
        instr_u ins;
        ins = '0;
        ins.i_view.opcode = OPC_OPIMM;
        return ins;
    endfunction

    function automatic logic [11:0] pick_csr(logic [2:0] k);
        case (k)
            3'd0:    return CSR_MSTATUS;
            3'd1:    return CSR_MTVEC;
            3'd2:    return CSR_MEPC;
            3'd3:    return CSR_MCAUSE;
            default: return 12'h7c0;
        endcase
    endfunction

    // bytes per access, from the low funct3 bits
    function automatic int access_size(logic [2:0] op);
        return 1 << op[1:0];
    endfunction

    function automatic logic [XLEN-1:0] model_load(logic [XLEN-1:0] addr, logic [2:0] op);
        logic [XLEN-1:0] val;
        logic            sign;
        int              base;
        int              n;
        val  = '0;
        base = int'(addr[8:0]);
        n    = access_size(op);
        for (int i = 0; i < n; i++) begin
            val[i*8 +: 8] = mem_m[base + i];
        end
        // funct3 bit 2 marks the unsigned loads
        sign = val[n*8-1];
        if (!op[2]) begin
            for (int i = n; i < 8; i++) begin
                val[i*8 +: 8] = {8{sign}};
            end
        end
        return val;
    endfunction

    task automatic check_load(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "load result mismatch");
        end
    endtask

    task automatic check_csr(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "csr value mismatch");
        end
    endtask

    // checks one cycle mid-period, then updates the model at the edge
    task automatic run_cycle(string name);
        logic [XLEN-1:0] exp_ld;
        logic [XLEN-1:0] old;
        logic [XLEN-1:0] nxt;
        logic [XLEN-1:0] st_val;
        logic            is_csr;
        logic            known;
        logic            fwd;
        int              base;
        exp_ld = '0;
        if (instr_i.i_view.opcode == OPC_LOAD) begin
            exp_ld = model_load(alures_i, instr_i.i_view.funct3);
        end
        is_csr = (instr_i.i_view.opcode == OPC_SYSTEM) && (instr_i.i_view.funct3[1:0] != 2'b00);
        known  = 1'b1;
        case (instr_i.i_view.imm12)
            CSR_MSTATUS: old = mstatus_m;
            CSR_MTVEC:   old = mtvec_m;
            CSR_MEPC:    old = mepc_m;
            CSR_MCAUSE:  old = mcause_m;
            default: begin
                old   = '0;
                known = 1'b0;
            end
        endcase
        @(negedge clk);
        check_load({name, " ls_res"}, exp_ld, ls_res_o);
        check_csr({name, " csr_data"}, is_csr ? old : '0, csr_data_o);
        check_csr({name, " mtvec"}, mtvec_m, mtvec_o);
        check_csr({name, " mepc"}, mepc_m, mepc_o);
        @(posedge clk);
        if (instr_i.s_view.opcode == OPC_STORE) begin
            // a load just ahead supplies the data for its rd
            fwd = (instr_last_i.i_view.opcode == OPC_LOAD) &&
                  (instr_last_i.i_view.rd == instr_i.s_view.rs2);
            st_val = fwd ? wb_data_i : rs2_i;
            base   = int'(alures_i[8:0]);
            for (int i = 0; i < access_size(instr_i.s_view.funct3); i++) begin
                mem_m[base + i] = st_val[i*8 +: 8];
            end
        end
        if (trap_i) begin
            mepc_m   = pc_i;
            mcause_m = CAUSE_ECALL_M;
        end else if (is_csr && known) begin
            case (instr_i.i_view.funct3[1:0])
                2'b01:   nxt = alures_i;
                2'b10:   nxt = old | alures_i;
                default: nxt = old & ~alures_i;
            endcase
            case (instr_i.i_view.imm12)
                CSR_MSTATUS: mstatus_m = nxt;
                CSR_MTVEC:   mtvec_m = nxt & ~64'h3;
                CSR_MEPC:    mepc_m = nxt;
                default:     mcause_m = nxt;
            endcase
        end
        #2;
    endtask

    initial begin
        logic [31:0] r;
        logic [5:0]  idx;
        logic [2:0]  off;
        logic [2:0]  op;
        logic [4:0]  rd;
        seed         = 32'h5725382d;
        reset_i      = 1'b1;
        pc_i         = '0;
        alures_i     = '0;
        rs2_i        = '0;
        wb_data_i    = '0;
        trap_i       = 1'b0;
        instr_i      = enc_nop();
        instr_last_i = enc_nop();
        mstatus_m    = '0;
        mtvec_m      = MTVEC_RST;
        mepc_m       = '0;
        mcause_m     = '0;
        repeat (4) @(posedge clk);
        #2;
        reset_i = 1'b0;
        run_cycle("reset");

        // every word written once, then read back
        for (int w = 0; w < N_WORDS; w++) begin
            instr_i  = enc_store(MEM_D, 5'd7);
            alures_i = {55'b0, 6'(w), 3'b000};
            rs2_i    = rand64();
            run_cycle("fill_st");
        end
        for (int w = 0; w < N_WORDS; w++) begin
            instr_i  = enc_load(MEM_D, 5'd8);
            alures_i = {55'b0, 6'(w), 3'b000};
            run_cycle("fill_ld");
        end

        for (int k = 0; k < 1000; k++) begin
            r   = rand32();
            idx = r[5:0];
            op  = r[8:6];
            if (r[9]) begin
                op      = {1'b0, op[1:0]};
                instr_i = enc_store(op, r[14:10]);
            end else begin
                if (op == 3'b111) begin
                    op = MEM_D;
                end
                instr_i = enc_load(op, r[14:10]);
            end
            off       = r[17:15] & ~3'(access_size(op) - 1);
            alures_i  = {55'b0, idx, off};
            rs2_i     = rand64();
            wb_data_i = rand64();
            run_cycle(r[9] ? "rand_st" : "rand_ld");
        end

        // load, then store reading that rd or a different one, then check
        for (int k = 0; k < 20; k++) begin
            r            = rand32();
            rd           = r[4:0];
            idx          = r[10:5];
            instr_last_i = enc_nop();
            instr_i      = enc_load(MEM_D, rd);
            alures_i     = {55'b0, idx, 3'b000};
            run_cycle("fwd_ld");
            instr_last_i = instr_i;
            instr_i      = enc_store(MEM_D, r[11] ? rd : rd + 5'd1);
            rs2_i        = rand64();
            wb_data_i    = rand64();
            run_cycle(r[11] ? "fwd_hit_st" : "fwd_miss_st");
            instr_last_i = instr_i;
            instr_i      = enc_load(MEM_D, 5'd9);
            run_cycle(r[11] ? "fwd_hit_ld" : "fwd_miss_ld");
        end

        instr_last_i = enc_nop();
        for (int k = 0; k < 500; k++) begin
            r  = rand32();
            op = r[10:8];
            if (op[1:0] == 2'b00) begin
                op[0] = 1'b1;
            end
            instr_i  = enc_csr(op, pick_csr(3'(r % 5)));
            alures_i = rand64();
            pc_i     = rand64() & ~64'h3;
            trap_i   = (r[13:11] == 3'b000);
            run_cycle(trap_i ? "csr_trap" : "csr_rand");
        end

        // trap against a csr write to mcause in the same cycle
        instr_i  = enc_csr(CSR_RW, CSR_MCAUSE);
        alures_i = rand64();
        pc_i     = 64'h0000_0000_0000_2468;
        trap_i   = 1'b1;
        run_cycle("trap_wr");
        trap_i   = 1'b0;
        instr_i  = enc_csr(CSR_RS, CSR_MCAUSE);
        alures_i = '0;
        run_cycle("mcause_rd");
        instr_i = enc_nop();
        run_cycle("final");

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
rv_ls_pkg.sv
ls_ctrl.sv
lsu.sv
data_ram.sv
csr_unit.sv
ls_stage.sv
tb_ls_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the load/store stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_ls_stage -o sim_ls_stage
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_ls_stage 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "Simulation passed"
if [ $? -ne 0 ]; then
    echo "pass message not found"
    exit 1
fi
exit 0
